// ==== compile.f ====
src/cpu_pkg.sv
src/alu.sv
src/regfile.sv
src/controller.sv
src/forward.sv
src/pc.sv
src/regwalls.sv
src/top.sv
dv/top_properties.sv
dv/tb.sv

// ==== Bender.yml ====
package:
  name: andes_pipe

sources:
  - src/cpu_pkg.sv
  - src/alu.sv
  - src/regfile.sv
  - src/controller.sv
  - src/forward.sv
  - src/pc.sv
  - src/regwalls.sv
  - src/top.sv
  - target: test
    files:
      - dv/top_properties.sv
      - dv/tb.sv

// ==== dv/tb.sv ====
`timescale 1ns/1ns

module tb;
	localparam int store_tail = 30;

	logic clk;
	logic reset;
	logic [cpu_pkg::pc_width-1:0] IM_address;
	logic [cpu_pkg::xlen-1:0] instruction;
	logic DM_read;
	logic DM_write;
	logic [cpu_pkg::dm_addr_width-1:0] DM_address;
	logic [cpu_pkg::xlen-1:0] DM_in;
	logic [cpu_pkg::xlen-1:0] DM_out;
	logic alu_overflow;

	logic [31:0] imem [1024];
	logic [31:0] dmem [4096];
	logic [31:0] ref_mem [4096];
	logic [31:0] prog [$];
	logic [11:0] preload_addr [$];
	logic [31:0] preload_data [$];
	logic [11:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_ovf;
	int exp_loads;
	int store_idx;
	int ovf_seen;
	int reads_seen;
	int test_errors;
	int passed;
	int failed;
	int budget;
	int cycles;
	logic checking;
	logic [31:0] rng;

	top top_i (
		.clk(clk), .reset(reset), .IM_address(IM_address), .instruction(instruction),
		.DM_read(DM_read), .DM_write(DM_write), .DM_address(DM_address),
		.DM_in(DM_in), .DM_out(DM_out), .alu_overflow(alu_overflow)
	);

	bind top top_properties top_properties_i (.*);

	// both memories answer in the same cycle
	assign instruction = imem[IM_address];
	assign DM_out = dmem[DM_address];

	always @(posedge clk) begin
		if (DM_write)
			dmem[DM_address] <= DM_in;
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rr_word(input logic [4:0] sub, input int rt,
		input int ra, input int rb);
		cpu_pkg::instr_t v;
		v = '0;
		v.r_form.opcode = cpu_pkg::op_alu;
		v.r_form.rt = rt[4:0];
		v.r_form.ra = ra[4:0];
		v.r_form.rb = rb[4:0];
		v.r_form.sub_op = sub;
		return v;
	endfunction

	function automatic logic [31:0] ri_word(input logic [5:0] op, input int rt,
		input int ra, input int imm);
		cpu_pkg::instr_t v;
		v = '0;
		v.i_form.opcode = op;
		v.i_form.rt = rt[4:0];
		v.i_form.ra = ra[4:0];
		v.i_form.imm15 = imm[14:0];
		return v;
	endfunction

	function automatic logic [31:0] jump_word(input int offset);
		cpu_pkg::instr_t v;
		v = '0;
		v.j_form.opcode = cpu_pkg::op_j;
		v.j_form.imm24 = offset[23:0];
		return v;
	endfunction

	// every data word carries its own address
	function automatic logic [31:0] fill_word(input int a);
		return {a[11:0] ^ 12'h5a3, 8'hc6, a[11:0]};
	endfunction

	task automatic preload(input int addr, input logic [31:0] data);
		preload_addr.push_back(addr[11:0]);
		preload_data.push_back(data);
	endtask

	task automatic load_memories();
		for (int a = 0; a < 1024; a++)
			imem[a] = (a < prog.size()) ? prog[a] : 32'h0;
		for (int a = 0; a < 4096; a++) begin
			dmem[a] = fill_word(a);
			ref_mem[a] = fill_word(a);
		end
		foreach (preload_addr[i]) begin
			dmem[preload_addr[i]] = preload_data[i];
			ref_mem[preload_addr[i]] = preload_data[i];
		end
		preload_addr.delete();
		preload_data.delete();
	endtask

	// one instruction per step until a jump to itself
	function automatic int ref_run();
		logic [31:0] r [32];
		cpu_pkg::instr_t w;
		logic [9:0] pc;
		logic [9:0] pc_next;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] sx;
		logic [31:0] jx;
		logic [31:0] sum;
		logic [32:0] wide;
		logic wr;
		logic arith;
		int steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		pc = '0;
		steps = 0;
		exp_ovf = 0;
		exp_loads = 0;
		exp_addr.delete();
		exp_data.delete();
		while (steps < 4000) begin
			w = imem[pc];
			steps++;
			a = r[w.i_form.ra];
			b = r[w.r_form.rb];
			sx = {{17{w.i_form.imm15[14]}}, w.i_form.imm15};
			jx = {{8{w.j_form.imm24[23]}}, w.j_form.imm24};
			sum = a + sx;
			wr = 1'b0;
			arith = 1'b0;
			res = '0;
			wide = '0;
			pc_next = pc + 10'd1;
			case (w.r_form.opcode)
				cpu_pkg::op_alu: begin
					wr = 1'b1;
					case (w.r_form.sub_op)
						cpu_pkg::sub_sub: begin
							res = a - b;
							wide = {a[31], a} - {b[31], b};
							arith = 1'b1;
						end
						cpu_pkg::sub_and: res = a & b;
						cpu_pkg::sub_or: res = a | b;
						cpu_pkg::sub_xor: res = a ^ b;
						default: begin
							res = a + b;
							wide = {a[31], a} + {b[31], b};
							arith = 1'b1;
						end
					endcase
				end
				cpu_pkg::op_addi: begin
					wr = 1'b1;
					res = sum;
					wide = {a[31], a} + {sx[31], sx};
					arith = 1'b1;
				end
				cpu_pkg::op_ori: begin
					wr = 1'b1;
					res = a | {17'b0, w.i_form.imm15};
				end
				cpu_pkg::op_lwi: begin
					wr = 1'b1;
					res = ref_mem[sum[11:0]];
					exp_loads++;
				end
				cpu_pkg::op_swi: begin
					exp_addr.push_back(sum[11:0]);
					exp_data.push_back(r[w.i_form.rt]);
					ref_mem[sum[11:0]] = r[w.i_form.rt];
				end
				cpu_pkg::op_beq: begin
					if (r[w.i_form.rt] == a)
						pc_next = pc + sx[9:0];
				end
				cpu_pkg::op_j: begin
					if (w.j_form.imm24 == '0)
						return steps;
					pc_next = pc + jx[9:0];
				end
				default: ;
			endcase
			if (arith && wide[32] != wide[31])
				exp_ovf++;
			if (wr && w.i_form.rt != 0)
				r[w.i_form.rt] = res;
			pc = pc_next;
		end
		return steps;
	endfunction

	// stores at forwarding distance 1, 2 and 3 with r0 as source and target
	task automatic alu_program();
		prog.push_back(ri_word(cpu_pkg::op_addi, 1, 0, 'h1234));
		prog.push_back(ri_word(cpu_pkg::op_ori, 2, 0, 'h5a5a));
		prog.push_back(rr_word(cpu_pkg::sub_add, 3, 1, 2));
		prog.push_back(ri_word(cpu_pkg::op_swi, 3, 0, 'h100));
		prog.push_back(rr_word(cpu_pkg::sub_sub, 4, 1, 2));
		prog.push_back(ri_word(cpu_pkg::op_addi, 9, 0, -5));
		prog.push_back(ri_word(cpu_pkg::op_swi, 4, 0, 'h101));
		prog.push_back(rr_word(cpu_pkg::sub_xor, 5, 1, 2));
		prog.push_back(ri_word(cpu_pkg::op_addi, 9, 9, 1));
		prog.push_back(ri_word(cpu_pkg::op_addi, 10, 9, 1));
		prog.push_back(ri_word(cpu_pkg::op_swi, 5, 0, 'h102));
		prog.push_back(rr_word(cpu_pkg::sub_and, 6, 3, 5));
		prog.push_back(rr_word(cpu_pkg::sub_or, 7, 6, 0));
		prog.push_back(rr_word(cpu_pkg::sub_add, 0, 1, 2));
		prog.push_back(ri_word(cpu_pkg::op_swi, 0, 0, 'h103));
		prog.push_back(ri_word(cpu_pkg::op_swi, 7, 0, 'h104));
		prog.push_back(ri_word(cpu_pkg::op_swi, 10, 0, 'h105));
		prog.push_back(jump_word(0));
	endtask

	// one slot at least between each load and its use
	task automatic load_program();
		prog.push_back(ri_word(cpu_pkg::op_addi, 1, 0, 'h40));
		prog.push_back(ri_word(cpu_pkg::op_lwi, 2, 1, 5));
		prog.push_back(ri_word(cpu_pkg::op_lwi, 3, 1, 6));
		prog.push_back(ri_word(cpu_pkg::op_addi, 8, 0, -3));
		prog.push_back(rr_word(cpu_pkg::sub_add, 4, 2, 3));
		prog.push_back(ri_word(cpu_pkg::op_swi, 4, 1, 'h200));
		prog.push_back(ri_word(cpu_pkg::op_lwi, 5, 1, 'h200));
		prog.push_back(ri_word(cpu_pkg::op_addi, 9, 0, 0));
		prog.push_back(ri_word(cpu_pkg::op_swi, 5, 1, -1));
		prog.push_back(rr_word(cpu_pkg::sub_sub, 6, 5, 2));
		prog.push_back(ri_word(cpu_pkg::op_swi, 6, 8, 0));
		prog.push_back(ri_word(cpu_pkg::op_swi, 2, 8, -2));
		prog.push_back(jump_word(0));
	endtask

	// marker stores sit in every killed slot
	task automatic branch_program();
		prog.push_back(ri_word(cpu_pkg::op_addi, 1, 0, 5));
		prog.push_back(ri_word(cpu_pkg::op_addi, 2, 0, 5));
		prog.push_back(ri_word(cpu_pkg::op_beq, 1, 2, 3));
		prog.push_back(ri_word(cpu_pkg::op_swi, 1, 0, 'h300));
		prog.push_back(ri_word(cpu_pkg::op_swi, 1, 0, 'h301));
		prog.push_back(ri_word(cpu_pkg::op_addi, 3, 0, 9));
		prog.push_back(ri_word(cpu_pkg::op_beq, 3, 1, 3));
		prog.push_back(ri_word(cpu_pkg::op_swi, 3, 0, 'h302));
		prog.push_back(jump_word(3));
		prog.push_back(ri_word(cpu_pkg::op_swi, 3, 0, 'h303));
		prog.push_back(ri_word(cpu_pkg::op_swi, 3, 0, 'h304));
		prog.push_back(ri_word(cpu_pkg::op_swi, 2, 0, 'h305));
		prog.push_back(ri_word(cpu_pkg::op_addi, 4, 0, 3));
		prog.push_back(ri_word(cpu_pkg::op_addi, 5, 0, 0));
		// loop body runs three passes
		prog.push_back(ri_word(cpu_pkg::op_addi, 5, 5, 2));
		prog.push_back(ri_word(cpu_pkg::op_addi, 4, 4, -1));
		prog.push_back(ri_word(cpu_pkg::op_beq, 4, 0, 3));
		prog.push_back(jump_word(-3));
		prog.push_back(ri_word(cpu_pkg::op_swi, 4, 0, 'h306));
		prog.push_back(ri_word(cpu_pkg::op_swi, 5, 0, 'h307));
		prog.push_back(jump_word(0));
	endtask

	task automatic overflow_program();
		preload('h10, 32'h7fffffff);
		preload('h11, 32'h80000000);
		preload('h12, 32'h00000001);
		prog.push_back(ri_word(cpu_pkg::op_lwi, 1, 0, 'h10));
		prog.push_back(ri_word(cpu_pkg::op_lwi, 2, 0, 'h11));
		prog.push_back(ri_word(cpu_pkg::op_lwi, 3, 0, 'h12));
		prog.push_back(ri_word(cpu_pkg::op_addi, 9, 0, 0));
		prog.push_back(rr_word(cpu_pkg::sub_add, 4, 1, 3));
		prog.push_back(rr_word(cpu_pkg::sub_sub, 5, 2, 3));
		prog.push_back(ri_word(cpu_pkg::op_addi, 6, 1, 1));
		prog.push_back(rr_word(cpu_pkg::sub_add, 7, 1, 2));
		prog.push_back(rr_word(cpu_pkg::sub_sub, 8, 3, 2));
		prog.push_back(ri_word(cpu_pkg::op_addi, 10, 2, -1));
		prog.push_back(rr_word(cpu_pkg::sub_or, 11, 1, 2));
		prog.push_back(ri_word(cpu_pkg::op_addi, 12, 3, -2));
		for (int i = 4; i <= 12; i++)
			prog.push_back(ri_word(cpu_pkg::op_swi, i, 0, 'h500 + i));
		prog.push_back(jump_word(0));
	endtask

	task automatic random_program();
		int kind;
		int rt;
		int ra;
		int rb;
		int imm;
		for (int i = 0; i < 60; i++) begin
			rng = xorshift(rng);
			kind = int'(rng % 7);
			rt = int'(rng[12:8]);
			ra = int'(rng[17:13]);
			rb = int'(rng[22:18]);
			rng = xorshift(rng);
			imm = int'(rng[14:0]);
			case (kind)
				0: prog.push_back(rr_word(cpu_pkg::sub_add, rt, ra, rb));
				1: prog.push_back(rr_word(cpu_pkg::sub_sub, rt, ra, rb));
				2: prog.push_back(rr_word(cpu_pkg::sub_and, rt, ra, rb));
				3: prog.push_back(rr_word(cpu_pkg::sub_or, rt, ra, rb));
				4: prog.push_back(rr_word(cpu_pkg::sub_xor, rt, ra, rb));
				5: prog.push_back(ri_word(cpu_pkg::op_addi, rt, ra, imm));
				default: prog.push_back(ri_word(cpu_pkg::op_ori, rt, ra, imm));
			endcase
		end
		for (int i = 0; i < 32; i++)
			prog.push_back(ri_word(cpu_pkg::op_swi, i, 0, 'h600 + i));
		prog.push_back(jump_word(0));
	endtask

	// store, load and overflow compare plus strobe check during reset
	always @(negedge clk) begin
		if (reset) begin
			assert (DM_read === 1'b0 && DM_write === 1'b0) else begin
				$display("a data memory strobe is high during reset");
				test_errors++;
			end
		end else if (checking) begin
			if (alu_overflow)
				ovf_seen++;
			if (DM_read)
				reads_seen++;
			if (DM_write) begin
				assert (store_idx < exp_addr.size()) else begin
					$display("store to address %h that the program never makes", DM_address);
					test_errors++;
				end
				if (store_idx < exp_addr.size()) begin
					assert (DM_address == exp_addr[store_idx]) else begin
						$display("ERR DM_address exp %h got %h", exp_addr[store_idx], DM_address);
						test_errors++;
					end
					assert (DM_in == exp_data[store_idx]) else begin
						$display("ERR DM_in exp %h got %h", exp_data[store_idx], DM_in);
						test_errors++;
					end
					store_idx++;
				end
			end
		end
	end

	task automatic run_test(input string name);
		int steps;
		int n;
		int checker_errors;
		test_errors = 0;
		checker_errors = top_i.top_properties_i.error_count;
		budget += 100;
		@(posedge clk);
		reset <= 1'b1;
		checking <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		load_memories();
		steps = ref_run();
		budget += steps * 4;
		store_idx = 0;
		ovf_seen = 0;
		reads_seen = 0;
		repeat (14) @(posedge clk);
		reset <= 1'b0;
		checking <= 1'b1;
		@(negedge clk);
		assert (IM_address == '0) else begin
			$display("ERR IM_address exp %h got %h", 10'h0, IM_address);
			test_errors++;
		end
		n = exp_addr.size();
		while (store_idx < n)
			@(posedge clk);
		repeat (store_tail) @(posedge clk);
		checking <= 1'b0;
		@(negedge clk);
		assert (ovf_seen == exp_ovf) else begin
			$display("ERR alu_overflow count exp %h got %h", exp_ovf, ovf_seen);
			test_errors++;
		end
		assert (reads_seen == exp_loads) else begin
			$display("ERR DM_read count exp %h got %h", exp_loads, reads_seen);
			test_errors++;
		end
		assert (top_i.top_properties_i.error_count == checker_errors) else begin
			$display("a memory port property failed during this test");
			test_errors++;
		end
		if (test_errors == 0) begin
			passed++;
			$display("%s: ok, %0d stores, %0d overflows", name, n, ovf_seen);
		end else begin
			failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
		prog.delete();
	endtask

	// budget grows as each test's length becomes known
	initial begin
		cycles = 0;
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run hung and was stopped after %0d cycles", cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		checking = 1'b0;
		rng = 32'hd3dc94f4;
		passed = 0;
		failed = 0;
		budget = 0;
		load_memories();
		alu_program();
		run_test("alu and forwarding");
		load_program();
		run_test("loads and stores");
		branch_program();
		run_test("branches and jumps");
		overflow_program();
		run_test("signed overflow");
		random_program();
		run_test("random alu program");
		$display("tests passed %0d failed %0d", passed, failed);
		if (failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/top_properties.sv ====
`timescale 1ns/1ns

module top_properties (
	input logic clk,
	input logic reset,
	input logic DM_read,
	input logic DM_write,
	input logic [cpu_pkg::dm_addr_width-1:0] DM_address,
	input logic [cpu_pkg::xlen-1:0] DM_in
);
	int error_count = 0;

	// one data memory access per cycle
	read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(DM_read && DM_write))
		else begin
			error_count++;
			$error("DM_read and DM_write are high in the same cycle");
		end

	// strobes come out of reset low
	strobes_low_in_reset: assert property (@(posedge clk)
		reset |=> (!DM_read && !DM_write))
		else begin
			error_count++;
			$error("a data memory strobe is high during reset");
		end

	store_known: assert property (@(posedge clk) disable iff (reset)
		DM_write |-> !$isunknown({DM_address, DM_in}))
		else begin
			error_count++;
			$error("store address or data is unknown while DM_write is high");
		end

endmodule

// ==== src/top.sv ====
`timescale 1ns/1ns

module top (
	input  logic clk,
	input  logic reset,
	output logic [cpu_pkg::pc_width-1:0] IM_address,
	input  logic [cpu_pkg::xlen-1:0] instruction,
	output logic DM_read,
	output logic DM_write,
	output logic [cpu_pkg::dm_addr_width-1:0] DM_address,
	output logic [cpu_pkg::xlen-1:0] DM_in,
	input  logic [cpu_pkg::xlen-1:0] DM_out,
	output logic alu_overflow
);
	// fetch
	logic [cpu_pkg::pc_width-1:0] current_pc;
	logic flush_fetch;

	// decode
	cpu_pkg::instr_t id_instruction;
	logic [cpu_pkg::pc_width-1:0] id_pc;
	logic [5:0] opcode;
	logic [4:0] sub_op;
	logic [cpu_pkg::reg_addr_width-1:0] ra_addr;
	logic [cpu_pkg::reg_addr_width-1:0] rb_addr;
	logic [cpu_pkg::reg_addr_width-1:0] rt_addr;
	logic [cpu_pkg::xlen-1:0] imm_extend;
	logic [cpu_pkg::pc_width-1:0] branch_offset;
	logic use_imm;
	logic is_beq;
	logic is_jump;
	logic do_reg_write;
	logic do_dm_read;
	logic do_dm_write;
	logic [cpu_pkg::xlen-1:0] ra_data;
	logic [cpu_pkg::xlen-1:0] rb_data;
	logic [cpu_pkg::xlen-1:0] rt_data;
	logic [cpu_pkg::xlen-1:0] f_ra_data;
	logic [cpu_pkg::xlen-1:0] f_rb_data;
	logic [cpu_pkg::xlen-1:0] f_rt_data;
	logic rt_ra_equal;

	// execute
	logic [cpu_pkg::xlen-1:0] ex_ra_data;
	logic [cpu_pkg::xlen-1:0] ex_rb_data;
	logic [cpu_pkg::xlen-1:0] ex_imm;
	logic ex_use_imm;
	logic [5:0] ex_opcode;
	logic [4:0] ex_sub_op;
	logic [cpu_pkg::reg_addr_width-1:0] ex_write_addr;
	logic ex_do_reg_write;
	logic ex_do_dm_read;
	logic [cpu_pkg::xlen-1:0] ex_result;
	logic ex_overflow;

	// memory and writeback
	logic [cpu_pkg::xlen-1:0] mem_result;
	logic [cpu_pkg::xlen-1:0] mem_rt_data;
	logic [cpu_pkg::reg_addr_width-1:0] mem_write_addr;
	logic mem_do_reg_write;
	logic [cpu_pkg::xlen-1:0] mem_write_data;
	logic [cpu_pkg::reg_addr_width-1:0] wb_write_addr;
	logic [cpu_pkg::xlen-1:0] wb_write_data;
	logic wb_do_reg_write;

	assign IM_address = current_pc;
	assign DM_address = mem_result[cpu_pkg::dm_addr_width-1:0];
	assign DM_in = mem_rt_data;

	pc pc_i (
		.clock(clk), .reset(reset), .decode_pc(id_pc),
		.is_beq(is_beq), .is_jump(is_jump), .rt_ra_equal(rt_ra_equal),
		.branch_offset(branch_offset), .current_pc(current_pc), .flush_fetch(flush_fetch)
	);

	controller controller_i (
		.instruction(id_instruction), .opcode(opcode), .sub_op(sub_op),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.imm_extend(imm_extend), .branch_offset(branch_offset), .use_imm(use_imm),
		.is_beq(is_beq), .is_jump(is_jump), .do_reg_write(do_reg_write),
		.do_dm_read(do_dm_read), .do_dm_write(do_dm_write)
	);

	regfile regfile_i (
		.clock(clk), .reset(reset),
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.write_addr(wb_write_addr), .write_data(wb_write_data), .write_en(wb_do_reg_write),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data)
	);

	forward forward_i (
		.ra_addr(ra_addr), .rb_addr(rb_addr), .rt_addr(rt_addr),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data),
		.ex_result(ex_result), .ex_write_addr(ex_write_addr),
		.ex_do_reg_write(ex_do_reg_write), .ex_do_dm_read(ex_do_dm_read),
		.mem_write_data(mem_write_data), .mem_write_addr(mem_write_addr),
		.mem_do_reg_write(mem_do_reg_write),
		.f_ra_data(f_ra_data), .f_rb_data(f_rb_data), .f_rt_data(f_rt_data),
		.rt_ra_equal(rt_ra_equal)
	);

	alu alu_i (
		.src1(ex_ra_data), .src2_reg(ex_rb_data), .imm(ex_imm), .use_imm(ex_use_imm),
		.opcode(ex_opcode), .sub_op(ex_sub_op), .result(ex_result), .overflow(ex_overflow)
	);

	regwalls regwalls_i (
		.clock(clk), .reset(reset), .flush_fetch(flush_fetch), .DM_out(DM_out),
		.if_instruction(instruction), .if_pc(current_pc),
		.id_instruction(id_instruction), .id_pc(id_pc),
		.id_ra_data(f_ra_data), .id_rb_data(f_rb_data), .id_rt_data(f_rt_data),
		.id_imm(imm_extend), .id_use_imm(use_imm), .id_opcode(opcode), .id_sub_op(sub_op),
		.id_write_addr(rt_addr), .id_do_reg_write(do_reg_write),
		.id_do_dm_read(do_dm_read), .id_do_dm_write(do_dm_write),
		.ex_ra_data(ex_ra_data), .ex_rb_data(ex_rb_data), .ex_imm(ex_imm),
		.ex_use_imm(ex_use_imm), .ex_opcode(ex_opcode), .ex_sub_op(ex_sub_op),
		.ex_write_addr(ex_write_addr), .ex_do_reg_write(ex_do_reg_write),
		.ex_do_dm_read(ex_do_dm_read),
		.ex_result(ex_result), .ex_overflow(ex_overflow),
		.mem_result(mem_result), .mem_rt_data(mem_rt_data),
		.mem_write_addr(mem_write_addr), .mem_do_reg_write(mem_do_reg_write),
		.mem_do_dm_read(DM_read), .mem_do_dm_write(DM_write),
		.mem_overflow(alu_overflow), .mem_write_data(mem_write_data),
		.wb_write_addr(wb_write_addr), .wb_write_data(wb_write_data),
		.wb_do_reg_write(wb_do_reg_write)
	);

endmodule

// ==== src/regwalls.sv ====
`timescale 1ns/1ns

module regwalls (
	input  logic clock,
	input  logic reset,
	input  logic flush_fetch,
	input  logic [cpu_pkg::xlen-1:0] DM_out,
	// REG1
	input  logic [cpu_pkg::xlen-1:0] if_instruction,
	input  logic [cpu_pkg::pc_width-1:0] if_pc,
	output cpu_pkg::instr_t id_instruction,
	output logic [cpu_pkg::pc_width-1:0] id_pc,
	// REG2
	input  logic [cpu_pkg::xlen-1:0] id_ra_data,
	input  logic [cpu_pkg::xlen-1:0] id_rb_data,
	input  logic [cpu_pkg::xlen-1:0] id_rt_data,
	input  logic [cpu_pkg::xlen-1:0] id_imm,
	input  logic id_use_imm,
	input  logic [5:0] id_opcode,
	input  logic [4:0] id_sub_op,
	input  logic [cpu_pkg::reg_addr_width-1:0] id_write_addr,
	input  logic id_do_reg_write,
	input  logic id_do_dm_read,
	input  logic id_do_dm_write,
	output logic [cpu_pkg::xlen-1:0] ex_ra_data,
	output logic [cpu_pkg::xlen-1:0] ex_rb_data,
	output logic [cpu_pkg::xlen-1:0] ex_imm,
	output logic ex_use_imm,
	output logic [5:0] ex_opcode,
	output logic [4:0] ex_sub_op,
	output logic [cpu_pkg::reg_addr_width-1:0] ex_write_addr,
	output logic ex_do_reg_write,
	output logic ex_do_dm_read,
	// REG3
	input  logic [cpu_pkg::xlen-1:0] ex_result,
	input  logic ex_overflow,
	output logic [cpu_pkg::xlen-1:0] mem_result,
	output logic [cpu_pkg::xlen-1:0] mem_rt_data,
	output logic [cpu_pkg::reg_addr_width-1:0] mem_write_addr,
	output logic mem_do_reg_write,
	output logic mem_do_dm_read,
	output logic mem_do_dm_write,
	output logic mem_overflow,
	output logic [cpu_pkg::xlen-1:0] mem_write_data,
	// REG4
	output logic [cpu_pkg::reg_addr_width-1:0] wb_write_addr,
	output logic [cpu_pkg::xlen-1:0] wb_write_data,
	output logic wb_do_reg_write
);
	logic [cpu_pkg::xlen-1:0] ex_rt_data;
	logic ex_do_dm_write;

	// load data arrives in the memory stage
	assign mem_write_data = mem_do_dm_read ? DM_out : mem_result;

	always_ff @(posedge clock) begin
		if (reset || flush_fetch)
			id_instruction <= '0;
		else
			id_instruction <= if_instruction;
		id_pc <= if_pc;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_opcode <= '0;
			ex_do_reg_write <= 1'b0;
			ex_do_dm_read <= 1'b0;
			ex_do_dm_write <= 1'b0;
		end else begin
			ex_opcode <= id_opcode;
			ex_do_reg_write <= id_do_reg_write;
			ex_do_dm_read <= id_do_dm_read;
			ex_do_dm_write <= id_do_dm_write;
		end
		ex_ra_data <= id_ra_data;
		ex_rb_data <= id_rb_data;
		ex_rt_data <= id_rt_data;
		ex_imm <= id_imm;
		ex_use_imm <= id_use_imm;
		ex_sub_op <= id_sub_op;
		ex_write_addr <= id_write_addr;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_do_reg_write <= 1'b0;
			mem_do_dm_read <= 1'b0;
			mem_do_dm_write <= 1'b0;
			mem_overflow <= 1'b0;
		end else begin
			mem_do_reg_write <= ex_do_reg_write;
			mem_do_dm_read <= ex_do_dm_read;
			mem_do_dm_write <= ex_do_dm_write;
			mem_overflow <= ex_overflow;
		end
		mem_result <= ex_result;
		mem_rt_data <= ex_rt_data;
		mem_write_addr <= ex_write_addr;
	end

	always_ff @(posedge clock) begin
		if (reset)
			wb_do_reg_write <= 1'b0;
		else
			wb_do_reg_write <= mem_do_reg_write;
		wb_write_addr <= mem_write_addr;
		wb_write_data <= mem_write_data;
	end

endmodule

// ==== src/pc.sv ====
`timescale 1ns/1ns

module pc (
	input  logic clock,
	input  logic reset,
	input  logic [cpu_pkg::pc_width-1:0] decode_pc,
	input  logic is_beq,
	input  logic is_jump,
	input  logic rt_ra_equal,
	input  logic [cpu_pkg::pc_width-1:0] branch_offset,
	output logic [cpu_pkg::pc_width-1:0] current_pc,
	output logic flush_fetch
);
	logic taken;
	logic [cpu_pkg::pc_width-1:0] next_pc;

	assign taken = is_jump || (is_beq && rt_ra_equal);

	// target is relative to the branch in decode, not to the fetch pc
	assign next_pc = taken ? decode_pc + branch_offset : current_pc + 1'b1;

	// the word fetched this cycle is on the wrong path
	assign flush_fetch = taken;

	always_ff @(posedge clock) begin
		if (reset)
			current_pc <= '0;
		else
			current_pc <= next_pc;
	end

endmodule

// ==== src/forward.sv ====
`timescale 1ns/1ns

module forward (
	input  logic [cpu_pkg::reg_addr_width-1:0] ra_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] rb_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
	input  logic [cpu_pkg::xlen-1:0] ra_data,
	input  logic [cpu_pkg::xlen-1:0] rb_data,
	input  logic [cpu_pkg::xlen-1:0] rt_data,
	input  logic [cpu_pkg::xlen-1:0] ex_result,
	input  logic [cpu_pkg::reg_addr_width-1:0] ex_write_addr,
	input  logic ex_do_reg_write,
	input  logic ex_do_dm_read,
	input  logic [cpu_pkg::xlen-1:0] mem_write_data,
	input  logic [cpu_pkg::reg_addr_width-1:0] mem_write_addr,
	input  logic mem_do_reg_write,
	output logic [cpu_pkg::xlen-1:0] f_ra_data,
	output logic [cpu_pkg::xlen-1:0] f_rb_data,
	output logic [cpu_pkg::xlen-1:0] f_rt_data,
	output logic rt_ra_equal
);
	// newest producer wins, a load in execute has no data yet
	function automatic logic [cpu_pkg::xlen-1:0] pick(
		input logic [cpu_pkg::reg_addr_width-1:0] addr,
		input logic [cpu_pkg::xlen-1:0] rf_data
	);
		if (ex_do_reg_write && !ex_do_dm_read && ex_write_addr != '0 && ex_write_addr == addr)
			return ex_result;
		if (mem_do_reg_write && mem_write_addr != '0 && mem_write_addr == addr)
			return mem_write_data;
		return rf_data;
	endfunction

	always_comb begin
		f_ra_data = pick(ra_addr, ra_data);
		f_rb_data = pick(rb_addr, rb_data);
		f_rt_data = pick(rt_addr, rt_data);
	end

	// beq compare in decode
	assign rt_ra_equal = (f_rt_data == f_ra_data);

endmodule

// ==== src/controller.sv ====
`timescale 1ns/1ns

module controller (
	input  cpu_pkg::instr_t instruction,
	output logic [5:0] opcode,
	output logic [4:0] sub_op,
	output logic [cpu_pkg::reg_addr_width-1:0] ra_addr,
	output logic [cpu_pkg::reg_addr_width-1:0] rb_addr,
	output logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
	output logic [cpu_pkg::xlen-1:0] imm_extend,
	output logic [cpu_pkg::pc_width-1:0] branch_offset,
	output logic use_imm,
	output logic is_beq,
	output logic is_jump,
	output logic do_reg_write,
	output logic do_dm_read,
	output logic do_dm_write
);
	logic [14:0] imm15;

	assign imm15 = instruction.i_form.imm15;

	always_comb begin
		opcode = instruction.r_form.opcode;
		sub_op = instruction.r_form.sub_op;
		rt_addr = instruction.r_form.rt;
		ra_addr = instruction.r_form.ra;
		rb_addr = instruction.r_form.rb;
		imm_extend = {{(cpu_pkg::xlen-15){imm15[14]}}, imm15};
		// sign-extended offset, kept to pc width
		branch_offset = imm15[cpu_pkg::pc_width-1:0];
		use_imm = 1'b0;
		is_beq = 1'b0;
		is_jump = 1'b0;
		do_reg_write = 1'b0;
		do_dm_read = 1'b0;
		do_dm_write = 1'b0;

		case (opcode)
			cpu_pkg::op_alu: begin
				do_reg_write = 1'b1;
			end
			cpu_pkg::op_addi: begin
				use_imm = 1'b1;
				do_reg_write = 1'b1;
			end
			cpu_pkg::op_ori: begin
				use_imm = 1'b1;
				do_reg_write = 1'b1;
				imm_extend = {{(cpu_pkg::xlen-15){1'b0}}, imm15};
			end
			cpu_pkg::op_lwi: begin
				use_imm = 1'b1;
				do_dm_read = 1'b1;
				do_reg_write = 1'b1;
			end
			cpu_pkg::op_swi: begin
				use_imm = 1'b1;
				do_dm_write = 1'b1;
			end
			cpu_pkg::op_beq: begin
				is_beq = 1'b1;
			end
			cpu_pkg::op_j: begin
				is_jump = 1'b1;
				branch_offset = instruction.j_form.imm24[cpu_pkg::pc_width-1:0];
			end
			// anything else behaves as a bubble
			default: ;
		endcase
	end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ns

module regfile (
	input  logic clock,
	input  logic reset,
	input  logic [cpu_pkg::reg_addr_width-1:0] ra_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] rb_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
	input  logic [cpu_pkg::reg_addr_width-1:0] write_addr,
	input  logic [cpu_pkg::xlen-1:0] write_data,
	input  logic write_en,
	output logic [cpu_pkg::xlen-1:0] ra_data,
	output logic [cpu_pkg::xlen-1:0] rb_data,
	output logic [cpu_pkg::xlen-1:0] rt_data
);
	logic [cpu_pkg::xlen-1:0] regs [32];

	// r0 is hardwired, same-cycle write passes straight through
	function automatic logic [cpu_pkg::xlen-1:0] read_port(
		input logic [cpu_pkg::reg_addr_width-1:0] addr
	);
		if (addr == '0)
			return '0;
		if (write_en && write_addr == addr)
			return write_data;
		return regs[addr];
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  logic [cpu_pkg::xlen-1:0] src1,
	input  logic [cpu_pkg::xlen-1:0] src2_reg,
	input  logic [cpu_pkg::xlen-1:0] imm,
	input  logic use_imm,
	input  logic [5:0] opcode,
	input  logic [4:0] sub_op,
	output logic [cpu_pkg::xlen-1:0] result,
	output logic overflow
);
	logic [cpu_pkg::xlen-1:0] src2;
	logic [4:0] op;
	logic sign_a;
	logic sign_b;
	logic sign_r;

	assign src2 = use_imm ? imm : src2_reg;
	assign sign_a = src1[cpu_pkg::xlen-1];
	assign sign_b = src2[cpu_pkg::xlen-1];
	assign sign_r = result[cpu_pkg::xlen-1];

	// immediate forms map onto a register sub-op
	always_comb begin
		case (opcode)
			cpu_pkg::op_alu: op = sub_op;
			cpu_pkg::op_ori: op = cpu_pkg::sub_or;
			default: op = cpu_pkg::sub_add;
		endcase
	end

	always_comb begin
		case (op)
			cpu_pkg::sub_sub: result = src1 - src2;
			cpu_pkg::sub_and: result = src1 & src2;
			cpu_pkg::sub_or:  result = src1 | src2;
			cpu_pkg::sub_xor: result = src1 ^ src2;
			default: result = src1 + src2;
		endcase
	end

	// signed overflow, arithmetic instructions only
	always_comb begin
		overflow = 1'b0;
		if (opcode == cpu_pkg::op_alu || opcode == cpu_pkg::op_addi) begin
			if (op == cpu_pkg::sub_add)
				overflow = (sign_a == sign_b) && (sign_r != sign_a);
			else if (op == cpu_pkg::sub_sub)
				overflow = (sign_a != sign_b) && (sign_r != sign_a);
		end
	end

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	localparam int xlen = 32;
	localparam int pc_width = 10;
	localparam int dm_addr_width = 12;
	localparam int reg_addr_width = 5;

	// major opcodes, instruction bits 30..25
	localparam logic [5:0] op_alu  = 6'b100000;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori  = 6'b101100;
	localparam logic [5:0] op_lwi  = 6'b000010;
	localparam logic [5:0] op_swi  = 6'b001010;
	localparam logic [5:0] op_beq  = 6'b100110;
	localparam logic [5:0] op_j    = 6'b100100;

	// register form sub-ops, bits 4..0
	localparam logic [4:0] sub_add = 5'b00000;
	localparam logic [4:0] sub_sub = 5'b00001;
	localparam logic [4:0] sub_and = 5'b00010;
	localparam logic [4:0] sub_xor = 5'b00011;
	localparam logic [4:0] sub_or  = 5'b00100;

	typedef union packed {
		struct packed {
			logic pad;
			logic [5:0] opcode;
			logic [reg_addr_width-1:0] rt;
			logic [reg_addr_width-1:0] ra;
			logic [reg_addr_width-1:0] rb;
			logic [4:0] unused;
			logic [4:0] sub_op;
		} r_form;
		struct packed {
			logic pad;
			logic [5:0] opcode;
			logic [reg_addr_width-1:0] rt;
			logic [reg_addr_width-1:0] ra;
			logic [14:0] imm15;
		} i_form;
		struct packed {
			logic pad;
			logic [5:0] opcode;
			logic [23:0] imm24;
			logic pad_low;
		} j_form;
	} instr_t;

endpackage
